// File: src/lockstep_pkg.sv
package lockstep_pkg;

  // Accumulator and operand width, the top level has to agree with it
  parameter int unsigned DataWidth = 32;

  // Width of the saturating mismatch counter
  parameter int unsigned MismatchCntW = 8;

  //////////////////////////////
  // Core opcodes
  //////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD  = 2'b00,
    OP_SUB  = 2'b01,
    OP_XOR  = 2'b10,
    OP_LOAD = 2'b11
  } core_op_e;

  //////////////////////////////
  // Core interface structs
  //////////////////////////////

  // One instruction as seen by the core in a cycle
  typedef struct packed {
    logic                 valid;
    core_op_e             op;
    logic [DataWidth-1:0] operand;
  } core_in_t;

  // Registered core outputs, compared bit for bit by the checker
  typedef struct packed {
    logic                 result_valid;
    logic                 zero;
    logic [DataWidth-1:0] acc;
  } core_out_t;

endpackage

// File: src/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
  parameter int unsigned Depth = 2,
  parameter int unsigned Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  // Stage 0 takes the input, the last stage drives the output
  logic [Width-1:0] stage_q [Depth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < Depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[Depth-1];

endmodule

// File: src/accum_core.sv
`timescale 1ns/1ps

module accum_core (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lockstep_pkg::core_in_t instr_i,
  output lockstep_pkg::core_out_t out_o
);

  logic [lockstep_pkg::DataWidth-1:0] acc_d;
  logic [lockstep_pkg::DataWidth-1:0] acc_q;
  logic                               valid_q;
  logic                               zero_d;
  logic                               zero_q;

  //////////////////////////////
  // Execute
  //////////////////////////////

  // Accumulator only moves on a valid instruction
  always_comb begin
    acc_d = acc_q;
    if (instr_i.valid) begin
      case (instr_i.op)
        lockstep_pkg::OP_ADD: begin
          acc_d = acc_q + instr_i.operand;
        end
        lockstep_pkg::OP_SUB: begin
          acc_d = acc_q - instr_i.operand;
        end
        lockstep_pkg::OP_XOR: begin
          acc_d = acc_q ^ instr_i.operand;
        end
        lockstep_pkg::OP_LOAD: begin
          acc_d = instr_i.operand;
        end
        default: begin
          acc_d = acc_q;
        end
      endcase
    end
  end

  // Flag follows the value the accumulator is about to take
  assign zero_d = (acc_d == '0);

  //////////////////////////////
  // State
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
      // Accumulator clears to zero, so the flag starts set
      zero_q  <= 1'b1;
    end else begin
      acc_q   <= acc_d;
      valid_q <= instr_i.valid;
      zero_q  <= zero_d;
    end
  end

  assign out_o.result_valid = valid_q;
  assign out_o.zero         = zero_q;
  assign out_o.acc          = acc_q;

endmodule

// File: src/shadow_path.sv
`timescale 1ns/1ps

module shadow_path #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  core_in_i,
  output lockstep_pkg::core_out_t shadow_out_o,
  output logic                    cmp_enable_o
);

  // Counter must hold LockstepOffset-1, one bit is the floor
  localparam int unsigned CntW = (LockstepOffset > 1) ? $clog2(LockstepOffset) : 1;
  localparam int unsigned InW  = $bits(lockstep_pkg::core_in_t);

  //////////////////////////////
  // Shadow reset
  //////////////////////////////

  logic [CntW-1:0] rst_cnt_d;
  logic [CntW-1:0] rst_cnt_q;
  logic            rst_set_d;
  logic            rst_set_q;
  logic            enable_cmp_q;

  // Stop counting once the offset has elapsed
  assign rst_set_d = (rst_cnt_q == CntW'(LockstepOffset - 1));
  assign rst_cnt_d = rst_set_d ? rst_cnt_q : rst_cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_cnt_q    <= '0;
      rst_set_q    <= 1'b0;
      enable_cmp_q <= 1'b0;
    end else begin
      rst_cnt_q    <= rst_cnt_d;
      rst_set_q    <= rst_set_d;
      // Compare starts the cycle after the shadow core leaves reset
      enable_cmp_q <= rst_set_q;
    end
  end

  assign cmp_enable_o = enable_cmp_q;

  //////////////////////////////
  // Input delay and core
  //////////////////////////////

  logic [InW-1:0]          instr_bits;
  logic [InW-1:0]          instr_dly_bits;
  lockstep_pkg::core_in_t  instr_dly;
  lockstep_pkg::core_out_t core_out;
  lockstep_pkg::core_out_t shadow_out_q;

  assign instr_bits = core_in_i;

  delay_line #(
    .Depth(LockstepOffset),
    .Width(InW)
  ) u_instr_dly (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (instr_bits),
    .q_o   (instr_dly_bits)
  );

  assign instr_dly = lockstep_pkg::core_in_t'(instr_dly_bits);

  accum_core u_shadow_core (
    .clk_i  (clk_i),
    .rst_ni (rst_set_q),
    .instr_i(instr_dly),
    .out_o  (core_out)
  );

  // One extra register stage on the shadow outputs
  always_ff @(posedge clk_i) begin
    shadow_out_q <= core_out;
  end

  assign shadow_out_o = shadow_out_q;

endmodule

// File: src/lockstep_compare.sv
`timescale 1ns/1ps

module lockstep_compare (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  cmp_enable_i,
  input  lockstep_pkg::core_out_t               shadow_out_i,
  input  lockstep_pkg::core_out_t               core_out_i,
  output logic                                  alert_major_o,
  output logic                                  alert_latched_o,
  output logic [lockstep_pkg::MismatchCntW-1:0] mismatch_cnt_o
);

  logic                                  mismatch;
  logic                                  latched_q;
  logic [lockstep_pkg::MismatchCntW-1:0] cnt_d;
  logic [lockstep_pkg::MismatchCntW-1:0] cnt_q;

  //////////////////////////////
  // Compare
  //////////////////////////////

  // Any differing bit counts, gated until the shadow core is running
  assign mismatch = cmp_enable_i & (shadow_out_i != core_out_i);

  // Saturate at all ones
  assign cnt_d = (mismatch && (cnt_q != '1)) ? cnt_q + 1'b1 : cnt_q;

  //////////////////////////////
  // Alert state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      latched_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      latched_q <= latched_q | mismatch;
      cnt_q     <= cnt_d;
    end
  end

  assign alert_major_o   = mismatch;
  assign alert_latched_o = latched_q;
  assign mismatch_cnt_o  = cnt_q;

endmodule

// File: src/lockstep_top.sv
`timescale 1ns/1ps

module lockstep_top #(
  parameter int unsigned LockstepOffset = 2,
  parameter int unsigned DataWidth      = lockstep_pkg::DataWidth
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  lockstep_pkg::core_in_t                core_in_i,
  input  lockstep_pkg::core_out_t               core_out_i,
  output logic                                  alert_major_o,
  output logic                                  alert_latched_o,
  output logic [lockstep_pkg::MismatchCntW-1:0] mismatch_cnt_o
);

  // Accumulator plus result_valid and zero
  localparam int unsigned CoreOutW = DataWidth + 2;

  lockstep_pkg::core_out_t shadow_out;
  lockstep_pkg::core_out_t core_out_dly;
  logic                    cmp_enable;
  logic [CoreOutW-1:0]     core_out_bits;
  logic [CoreOutW-1:0]     core_out_dly_bits;

  shadow_path #(
    .LockstepOffset(LockstepOffset)
  ) u_shadow_path (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_in_i   (core_in_i),
    .shadow_out_o(shadow_out),
    .cmp_enable_o(cmp_enable)
  );

  // Main core outputs wait one extra stage for the shadow output register
  assign core_out_bits = core_out_i;

  delay_line #(
    .Depth(LockstepOffset + 1),
    .Width(CoreOutW)
  ) u_core_out_dly (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (core_out_bits),
    .q_o   (core_out_dly_bits)
  );

  assign core_out_dly = lockstep_pkg::core_out_t'(core_out_dly_bits);

  lockstep_compare u_compare (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmp_enable_i   (cmp_enable),
    .shadow_out_i   (shadow_out),
    .core_out_i     (core_out_dly),
    .alert_major_o  (alert_major_o),
    .alert_latched_o(alert_latched_o),
    .mismatch_cnt_o (mismatch_cnt_o)
  );

endmodule

// File: test/tb_lockstep.sv
`timescale 1ns/1ps

module tb_lockstep;

  localparam int unsigned LockstepOffset = 2;
  localparam int unsigned DataWidth      = lockstep_pkg::DataWidth;
  localparam int unsigned OutW           = $bits(lockstep_pkg::core_out_t);
  localparam int unsigned CntW           = lockstep_pkg::MismatchCntW;
  // Cycles from a driven main-core output to its alert
  localparam int unsigned AlertLag       = LockstepOffset + 1;
  localparam int unsigned ClkPeriod      = 8;

  // Phase lengths in cycles
  localparam int unsigned ResetCycles  = 8;
  localparam int unsigned CleanCycles  = 300;
  localparam int unsigned SparseCycles = 400;
  localparam int unsigned DirectCycles = 10;
  localparam int unsigned BurstCycles  = 300;
  localparam int unsigned TailCycles   = 20;
  localparam int unsigned TotalCycles  = 2 * ResetCycles + CleanCycles + SparseCycles
                                       + DirectCycles + BurstCycles + TailCycles;
  localparam int unsigned MarginCycles = 100;
  localparam int unsigned TimeoutNs    = (TotalCycles + MarginCycles) * ClkPeriod;

  // Fault kinds
  localparam int FaultNone   = 0;
  localparam int FaultRandom = 1;
  localparam int FaultValid  = 2;
  localparam int FaultZero   = 3;
  localparam int FaultAcc    = 4;

  logic                    clk_i;
  logic                    rst_ni;
  lockstep_pkg::core_in_t  core_in_i;
  lockstep_pkg::core_out_t core_out_i;
  logic                    alert_major_o;
  logic                    alert_latched_o;
  logic [CntW-1:0]         mismatch_cnt_o;

  // Main-core model state
  logic [DataWidth-1:0] model_acc;
  logic                 model_valid;

  // Expected alert state
  logic [AlertLag-1:0]  fault_pipe;
  int unsigned          edges_since_release;
  logic                 exp_latched;
  logic [CntW-1:0]      exp_cnt;

  int unsigned          err_cnt;
  int unsigned          check_cnt;
  int unsigned          fault_cnt;

  lockstep_top #(
    .LockstepOffset(LockstepOffset),
    .DataWidth     (DataWidth)
  ) lockstep_top_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .core_in_i      (core_in_i),
    .core_out_i     (core_out_i),
    .alert_major_o  (alert_major_o),
    .alert_latched_o(alert_latched_o),
    .mismatch_cnt_o (mismatch_cnt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout after %0d ns, the stimulus did not complete", TimeoutNs);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input logic [CntW-1:0] got,
                             input logic [CntW-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////
  // Main-core model
  //////////////////////////////

  function automatic lockstep_pkg::core_out_t model_out();
    lockstep_pkg::core_out_t out_val;
    out_val.result_valid = model_valid;
    out_val.zero         = (model_acc == '0);
    out_val.acc          = model_acc;
    return out_val;
  endfunction

  // One rising edge of the main core
  task automatic execute_instr(input lockstep_pkg::core_in_t instr);
    model_valid = instr.valid;
    if (instr.valid) begin
      case (instr.op)
        lockstep_pkg::OP_ADD:  model_acc = model_acc + instr.operand;
        lockstep_pkg::OP_SUB:  model_acc = model_acc - instr.operand;
        lockstep_pkg::OP_XOR:  model_acc = model_acc ^ instr.operand;
        default:               model_acc = instr.operand;
      endcase
    end
  endtask

  task automatic clear_model();
    model_acc           = '0;
    model_valid         = 1'b0;
    fault_pipe          = '0;
    edges_since_release = 0;
    exp_latched         = 1'b0;
    exp_cnt             = '0;
  endtask

  function automatic lockstep_pkg::core_in_t random_instr();
    lockstep_pkg::core_in_t instr;
    instr.valid   = ($urandom % 8) != 0;
    instr.op      = lockstep_pkg::core_op_e'($urandom % 4);
    instr.operand = $urandom;
    // Loads of zero keep the zero flag moving
    if (($urandom % 6) == 0) begin
      instr.op      = lockstep_pkg::OP_LOAD;
      instr.operand = '0;
    end
    return instr;
  endfunction

  function automatic logic [OutW-1:0] fault_mask(input int kind);
    logic [OutW-1:0] mask;
    int unsigned     pick;
    int unsigned     bit_idx;
    pick = $urandom % 4;
    case (kind)
      FaultValid: bit_idx = OutW - 1;
      FaultZero:  bit_idx = DataWidth;
      FaultAcc:   bit_idx = $urandom % DataWidth;
      default: begin
        if (pick == 0) begin
          bit_idx = OutW - 1;
        end else if (pick == 1) begin
          bit_idx = DataWidth;
        end else begin
          bit_idx = $urandom % DataWidth;
        end
      end
    endcase
    mask          = '0;
    mask[bit_idx] = 1'b1;
    return mask;
  endfunction

  //////////////////////////////
  // One cycle of stimulus
  //////////////////////////////

  // Outputs are checked at the falling edge before new inputs are driven
  task automatic run_cycle(input logic rst_val, input int fault_kind);
    lockstep_pkg::core_in_t  instr;
    lockstep_pkg::core_out_t out_val;
    logic                    pred;
    logic                    fault;
    @(negedge clk_i);
    if (rst_ni) begin
      edges_since_release++;
    end
    pred = (edges_since_release >= AlertLag) && fault_pipe[AlertLag-1];
    check_flag("alert_major_o", alert_major_o, pred);
    check_flag("alert_latched_o", alert_latched_o, exp_latched);
    check_count("mismatch_cnt_o", mismatch_cnt_o, exp_cnt);
    // Sticky flag and counter take the alert on the next rising edge
    exp_latched = exp_latched | pred;
    if (pred && (exp_cnt != '1)) begin
      exp_cnt = exp_cnt + 1'b1;
    end
    rst_ni = rst_val;
    if (!rst_val) begin
      clear_model();
      core_in_i  = '0;
      core_out_i = model_out();
    end else begin
      instr   = random_instr();
      out_val = model_out();
      fault   = (fault_kind != FaultNone);
      if (fault) begin
        out_val = lockstep_pkg::core_out_t'(out_val ^ fault_mask(fault_kind));
        fault_cnt++;
      end
      core_in_i  = instr;
      core_out_i = out_val;
      fault_pipe = {fault_pipe[AlertLag-2:0], fault};
      execute_instr(instr);
    end
  endtask

  initial begin
    int unsigned seed;
    seed = 54;
    void'($urandom(seed));
    rst_ni     = 1'b0;
    core_in_i  = '0;
    core_out_i = '0;
    err_cnt    = 0;
    check_cnt  = 0;
    fault_cnt  = 0;
    clear_model();

    // First falling edge comes after the first rising edge
    @(posedge clk_i);
    repeat (ResetCycles) run_cycle(1'b0, FaultNone);
    // Fault-free stream
    repeat (CleanCycles) run_cycle(1'b1, FaultNone);
    // Sparse single-cycle faults on acc, result_valid and zero
    repeat (SparseCycles) begin
      run_cycle(1'b1, (($urandom % 12) == 0) ? FaultRandom : FaultNone);
    end
    // Reset in the middle of the run with faults right at compare enable
    repeat (ResetCycles) run_cycle(1'b0, FaultNone);
    for (int i = 0; i < DirectCycles; i++) begin
      case (i)
        0:       run_cycle(1'b1, FaultZero);
        2:       run_cycle(1'b1, FaultValid);
        5:       run_cycle(1'b1, FaultAcc);
        default: run_cycle(1'b1, FaultNone);
      endcase
    end
    // Long burst drives the counter into saturation
    repeat (BurstCycles) run_cycle(1'b1, FaultRandom);
    repeat (TailCycles) run_cycle(1'b1, FaultNone);

    $display("Checks: %0d, errors: %0d, faults injected: %0d", check_cnt, err_cnt, fault_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: lockstep.f
src/lockstep_pkg.sv
src/delay_line.sv
src/accum_core.sv
src/shadow_path.sv
src/lockstep_compare.sv
src/lockstep_top.sv
test/tb_lockstep.sv
